// ==== build.f ====
hdl/db_pkg.sv
hdl/htable_pkg.sv
hdl/htable_tbl_intf.sv
hdl/htable_store.sv
hdl/htable_cuckoo_core.sv
hdl/htable_cuckoo_top.sv
bench/htable_cuckoo_assertions.sv
bench/htable_cuckoo_tb.sv

// ==== bench/htable_cuckoo_tb.sv ====
module htable_cuckoo_tb;
    import db_pkg::*;
    import htable_pkg::*;

    // Operations issued by the sequence below, rounded up
    localparam int NUM_OPS    = 72;
    localparam int SWEEP      = 2 ** HASH_WID + 1;
    localparam int MAX_CYCLES = NUM_OPS * 8 + 2 * SWEEP;
    localparam int SLICE_WID  = NUM_TABLES * HASH_WID;

    logic       clk;
    logic       rst_n;
    logic       init_done;
    logic       ctrl_valid;
    logic       ctrl_ready;
    db_op_t     ctrl_op;
    key_t       ctrl_key;
    value_t     ctrl_value;
    logic       resp_valid;
    logic       resp_found;
    value_t     resp_value;
    db_status_t resp_status;
    logic       lookup_valid;
    logic       lookup_ready;
    key_t       lookup_key;
    logic       lookup_resp_valid;
    logic       lookup_found;
    value_t     lookup_value;

    // Reference model and the slot occupancy that the placement rule implies
    value_t model [key_t];
    logic   occ_valid [NUM_TABLES][2**HASH_WID];
    key_t   occ_key   [NUM_TABLES][2**HASH_WID];
    key_t   stored_keys [$];
    logic   exp_found_q [$];
    value_t exp_value_q [$];

    logic [31:0] lfsr_state = 32'h7e9f;
    int          errors = 0;
    int          cycle_count = 0;
    key_t        key;
    key_t        base;

    htable_cuckoo_top #(.NUM_TABLES(NUM_TABLES), .HASH_WID(HASH_WID)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================
    // Helpers
    // ============================

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    function automatic int slot_of(input key_t k, input int t);
        return k[t*HASH_WID +: HASH_WID];
    endfunction

    function automatic logic slot_in_use(input key_t k);
        logic used;
        used = 1'b0;
        for (int t = 0; t < NUM_TABLES; t++) begin
            used = used | occ_valid[t][slot_of(k, t)];
        end
        return used;
    endfunction

    // Matching key in the lowest table, else the lowest empty table
    function automatic void model_apply(input db_op_t op, input key_t k, input value_t v,
                                        output logic found, output value_t old,
                                        output db_status_t status);
        int hit;
        int empty;
        hit   = -1;
        empty = -1;
        for (int t = NUM_TABLES - 1; t >= 0; t--) begin
            if (occ_valid[t][slot_of(k, t)] && occ_key[t][slot_of(k, t)] == k) begin
                hit = t;
            end
            if (!occ_valid[t][slot_of(k, t)]) begin
                empty = t;
            end
        end
        found  = (op != OP_CLEAR) && (hit >= 0);
        old    = found ? model[k] : '0;
        status = (op == OP_SET && hit < 0 && empty < 0) ? ST_FULL : ST_OK;
        case (op)
            OP_SET: begin
                if (hit < 0 && empty >= 0) begin
                    occ_valid[empty][slot_of(k, empty)] = 1'b1;
                    occ_key[empty][slot_of(k, empty)]   = k;
                end
                if (hit >= 0 || empty >= 0) begin
                    model[k] = v;
                end
            end
            OP_UNSET: begin
                if (found) begin
                    occ_valid[hit][slot_of(k, hit)] = 1'b0;
                    model.delete(k);
                end
            end
            OP_CLEAR: begin
                model.delete();
                foreach (occ_valid[t, s]) begin
                    occ_valid[t][s] = 1'b0;
                end
            end
            default: ;
        endcase
    endfunction

    task automatic check_value(input string name, input value_t got, input value_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic run_ctrl(input db_op_t op, input key_t k, input value_t v);
        logic       exp_found;
        value_t     exp_value;
        db_status_t exp_status;
        model_apply(op, k, v, exp_found, exp_value, exp_status);
        ctrl_valid = 1'b1;
        ctrl_op    = op;
        ctrl_key   = k;
        ctrl_value = v;
        while (!ctrl_ready) begin
            @(posedge clk);
            #5;
        end
        @(posedge clk);
        #5;
        ctrl_valid = 1'b0;
        while (!resp_valid) begin
            @(posedge clk);
            #5;
        end
        check_value("resp_found", resp_found, exp_found);
        check_value("resp_value", resp_value, exp_value);
        check_value("resp_status", resp_status, exp_status);
    endtask

    task automatic issue_lookup(input key_t k);
        lookup_valid = 1'b1;
        lookup_key   = k;
        while (!lookup_ready) begin
            @(posedge clk);
            #5;
        end
        exp_found_q.push_back(model.exists(k));
        exp_value_q.push_back(model.exists(k) ? model[k] : '0);
        @(posedge clk);
        #5;
    endtask

    task automatic drain_lookups();
        lookup_valid = 1'b0;
        while (exp_found_q.size() != 0) begin
            @(posedge clk);
            #5;
        end
    endtask

    // Lookup results, in order, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && lookup_resp_valid) begin
            if (exp_found_q.size() == 0) begin
                errors++;
                $display("lookup result arrived with no query outstanding");
            end else begin
                check_value("lookup_found", lookup_found, exp_found_q.pop_front());
                check_value("lookup_value", lookup_value, exp_value_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ============================
    // Test sequence
    // ============================

    initial begin
        rst_n        = 1'b0;
        ctrl_valid   = 1'b0;
        ctrl_op      = OP_GET;
        ctrl_key     = '0;
        ctrl_value   = '0;
        lookup_valid = 1'b0;
        lookup_key   = '0;
        foreach (occ_valid[t, s]) begin
            occ_valid[t][s] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;

        // Empty table after the reset sweep
        run_ctrl(OP_GET, next_bits(KEY_WID), '0);

        // Insert, read back, replace, read back
        key = next_bits(KEY_WID);
        stored_keys.push_back(key);
        run_ctrl(OP_SET, key, next_bits(VALUE_WID));
        run_ctrl(OP_GET, key, '0);
        run_ctrl(OP_SET, key, next_bits(VALUE_WID));
        run_ctrl(OP_GET, key, '0);

        // Remove returns the old value
        key = next_bits(KEY_WID);
        stored_keys.push_back(key);
        run_ctrl(OP_SET, key, next_bits(VALUE_WID));
        run_ctrl(OP_UNSET, key, '0);
        run_ctrl(OP_GET, key, '0);

        // Keys sharing every slot, the last one finds all tables taken
        do begin
            base = next_bits(KEY_WID);
        end while (slot_in_use(base));
        for (int i = 1; i <= NUM_TABLES + 1; i++) begin
            stored_keys.push_back(base ^ (key_t'(i) << SLICE_WID));
            run_ctrl(OP_SET, stored_keys[$], next_bits(VALUE_WID));
        end
        for (int i = 1; i <= NUM_TABLES; i++) begin
            run_ctrl(OP_GET, base ^ (key_t'(i) << SLICE_WID), '0);
        end

        // A few more entries, then one lookup per cycle
        repeat (6) begin
            key = next_bits(KEY_WID);
            stored_keys.push_back(key);
            run_ctrl(OP_SET, key, next_bits(VALUE_WID));
        end
        repeat (24) begin
            if (next_bits(1)) begin
                issue_lookup(stored_keys[next_bits(8) % stored_keys.size()]);
            end else begin
                issue_lookup(next_bits(KEY_WID));
            end
        end
        drain_lookups();

        // Clear empties both ports
        run_ctrl(OP_CLEAR, '0, '0);
        foreach (stored_keys[i]) begin
            run_ctrl(OP_GET, stored_keys[i], '0);
        end
        foreach (stored_keys[i]) begin
            issue_lookup(stored_keys[i]);
        end
        drain_lookups();
        repeat (2) @(posedge clk);

        $display("error counts: %0d value, %0d assertion", errors, dut.u_assert.assert_errors);
        if (errors == 0 && dut.u_assert.assert_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== bench/htable_cuckoo_assertions.sv ====
module htable_cuckoo_assertions (
    input logic           clk,
    input logic           rst_n,
    input logic           init_done,
    input logic           ctrl_valid,
    input logic           ctrl_ready,
    input db_pkg::db_op_t ctrl_op,
    input logic           resp_valid,
    input logic           lookup_valid,
    input logic           lookup_ready,
    input logic           lookup_resp_valid
);
    import db_pkg::*;

    int   assert_errors = 0;
    logic busy;
    logic ctrl_accept;
    logic lookup_accept;

    assign ctrl_accept   = ctrl_valid && ctrl_ready;
    assign lookup_accept = lookup_valid && lookup_ready;

    function automatic void flag_failure(input string what);
        assert_errors++;
        $error("%s", what);
    endfunction

    // High from acceptance through the response cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (ctrl_accept) begin
            busy <= 1'b1;
        end else if (resp_valid) begin
            busy <= 1'b0;
        end
    end

    // ============================
    // Handshake and latency
    // ============================

    ready_before_init: assert property (@(posedge clk) disable iff (!rst_n)
        !init_done |-> !ctrl_ready && !lookup_ready)
        else flag_failure("ready raised while init_done is low");

    lookup_always_ready: assert property (@(posedge clk) disable iff (!rst_n)
        init_done |-> lookup_ready)
        else flag_failure("lookup_ready low while init_done is high");

    lookup_latency: assert property (@(posedge clk) disable iff (!rst_n)
        lookup_accept |-> ##2 lookup_resp_valid)
        else flag_failure("lookup result missing two cycles after acceptance");

    lookup_origin: assert property (@(posedge clk) disable iff (!rst_n)
        lookup_resp_valid |-> $past(lookup_accept, 2))
        else flag_failure("lookup result without a query two cycles earlier");

    get_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_accept && ctrl_op == OP_GET |-> ##3 resp_valid)
        else flag_failure("get response not three cycles after acceptance");

    write_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_accept && (ctrl_op == OP_SET || ctrl_op == OP_UNSET) |-> ##4 resp_valid)
        else flag_failure("set or unset response not four cycles after acceptance");

    single_response: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> busy)
        else flag_failure("response without an accepted request");

    ready_held_low: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !ctrl_ready)
        else flag_failure("ctrl_ready high while an operation is in progress");

    clear_sweep: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_accept && ctrl_op == OP_CLEAR |=> !init_done)
        else flag_failure("clear did not drop init_done");

endmodule

bind htable_cuckoo_top htable_cuckoo_assertions u_assert (.*);

// ==== hdl/htable_cuckoo_top.sv ====
module htable_cuckoo_top #(
    parameter int NUM_TABLES = htable_pkg::NUM_TABLES,
    parameter int HASH_WID   = htable_pkg::HASH_WID
) (
    input  logic               clk,
    input  logic               rst_n,
    output logic               init_done,
    input  logic               ctrl_valid,
    output logic               ctrl_ready,
    input  db_pkg::db_op_t     ctrl_op,
    input  htable_pkg::key_t   ctrl_key,
    input  htable_pkg::value_t ctrl_value,
    output logic               resp_valid,
    output logic               resp_found,
    output htable_pkg::value_t resp_value,
    output db_pkg::db_status_t resp_status,
    input  logic               lookup_valid,
    output logic               lookup_ready,
    input  htable_pkg::key_t   lookup_key,
    output logic               lookup_resp_valid,
    output logic               lookup_found,
    output htable_pkg::value_t lookup_value
);

    // One link per table between the core and its store
    htable_tbl_intf #(.HASH_WID(HASH_WID)) tbl_if [NUM_TABLES] ();

    htable_cuckoo_core #(
        .NUM_TABLES (NUM_TABLES),
        .HASH_WID   (HASH_WID)
    ) u_core (
        .clk               (clk),
        .rst_n             (rst_n),
        .init_done         (init_done),
        .ctrl_valid        (ctrl_valid),
        .ctrl_ready        (ctrl_ready),
        .ctrl_op           (ctrl_op),
        .ctrl_key          (ctrl_key),
        .ctrl_value        (ctrl_value),
        .resp_valid        (resp_valid),
        .resp_found        (resp_found),
        .resp_value        (resp_value),
        .resp_status       (resp_status),
        .lookup_valid      (lookup_valid),
        .lookup_ready      (lookup_ready),
        .lookup_key        (lookup_key),
        .lookup_resp_valid (lookup_resp_valid),
        .lookup_found      (lookup_found),
        .lookup_value      (lookup_value),
        .tbl               (tbl_if)
    );

    for (genvar i = 0; i < NUM_TABLES; i++) begin : g_store
        htable_store #(
            .HASH_WID (HASH_WID)
        ) u_store (
            .clk   (clk),
            .rst_n (rst_n),
            .tbl   (tbl_if[i])
        );
    end

endmodule

// ==== hdl/htable_cuckoo_core.sv ====
module htable_cuckoo_core #(
    parameter int NUM_TABLES = htable_pkg::NUM_TABLES,
    parameter int HASH_WID   = htable_pkg::HASH_WID
) (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   init_done,
    input  logic                   ctrl_valid,
    output logic                   ctrl_ready,
    input  db_pkg::db_op_t         ctrl_op,
    input  htable_pkg::key_t       ctrl_key,
    input  htable_pkg::value_t     ctrl_value,
    output logic                   resp_valid,
    output logic                   resp_found,
    output htable_pkg::value_t     resp_value,
    output db_pkg::db_status_t     resp_status,
    input  logic                   lookup_valid,
    output logic                   lookup_ready,
    input  htable_pkg::key_t       lookup_key,
    output logic                   lookup_resp_valid,
    output logic                   lookup_found,
    output htable_pkg::value_t     lookup_value,
    htable_tbl_intf.core           tbl [NUM_TABLES]
);
    import db_pkg::*;
    import htable_pkg::*;

    localparam int SEL_WID = (NUM_TABLES > 1) ? $clog2(NUM_TABLES) : 1;

    typedef enum logic [2:0] {IDLE, READ, DECIDE, WRITE, CLEAR} state_t;

    state_t state;

    // Latched control request
    db_op_t req_op;
    key_t   req_key;
    value_t req_value;

    logic               ctrl_accept;
    logic               lookup_accept;
    logic               clear_start;
    logic               wr_do;
    logic [SEL_WID-1:0] wr_sel;

    // Per-table read results
    logic [NUM_TABLES-1:0] store_done;
    logic [NUM_TABLES-1:0] rd_hit;
    logic [NUM_TABLES-1:0] rd_free;
    logic [NUM_TABLES-1:0] lk_hit;
    value_t                rd_value_arr [NUM_TABLES];
    value_t                lk_value_arr [NUM_TABLES];

    logic               hit;
    logic               free;
    logic [SEL_WID-1:0] hit_idx;
    logic [SEL_WID-1:0] free_idx;
    logic [SEL_WID-1:0] lk_idx;

    logic s1_valid;
    key_t s1_key;

    // Lowest set bit wins
    function automatic logic [SEL_WID-1:0] first_set(input logic [NUM_TABLES-1:0] vec);
        logic [SEL_WID-1:0] idx;
        idx = '0;
        for (int i = NUM_TABLES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = SEL_WID'(i);
            end
        end
        return idx;
    endfunction

    assign init_done     = &store_done;
    assign ctrl_ready    = (state == IDLE) && init_done && !resp_valid;
    assign lookup_ready  = init_done;
    assign ctrl_accept   = ctrl_valid && ctrl_ready;
    assign lookup_accept = lookup_valid && lookup_ready;
    assign clear_start   = ctrl_accept && (ctrl_op == OP_CLEAR);

    // ============================
    // Table connections
    // ============================

    for (genvar i = 0; i < NUM_TABLES; i++) begin : g_tbl
        assign tbl[i].rd_en    = (state == READ);
        assign tbl[i].rd_addr  = req_key[i*HASH_WID +: HASH_WID];
        assign tbl[i].lk_en    = lookup_accept;
        assign tbl[i].lk_addr  = lookup_key[i*HASH_WID +: HASH_WID];
        assign tbl[i].wr_en    = (state == WRITE) && wr_do && (wr_sel == SEL_WID'(i));
        assign tbl[i].wr_addr  = req_key[i*HASH_WID +: HASH_WID];
        assign tbl[i].wr_valid = (req_op == OP_SET);
        assign tbl[i].wr_key   = req_key;
        assign tbl[i].wr_value = req_value;
        assign tbl[i].init     = clear_start;

        assign store_done[i]   = tbl[i].init_done;
        assign rd_hit[i]       = tbl[i].rd_valid && (tbl[i].rd_key == req_key);
        assign rd_free[i]      = !tbl[i].rd_valid;
        assign lk_hit[i]       = tbl[i].lk_valid && (tbl[i].lk_key == s1_key);
        assign rd_value_arr[i] = tbl[i].rd_value;
        assign lk_value_arr[i] = tbl[i].lk_value;
    end

    assign hit      = |rd_hit;
    assign free     = |rd_free;
    assign hit_idx  = first_set(rd_hit);
    assign free_idx = first_set(rd_free);
    assign lk_idx   = first_set(lk_hit);

    // ============================
    // Control FSM
    // ============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
            wr_do      <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (ctrl_accept) begin
                        state <= (ctrl_op == OP_CLEAR) ? CLEAR : READ;
                    end
                end
                READ: state <= DECIDE;
                DECIDE: begin
                    // Existing key first, else the lowest empty slot
                    wr_do <= ((req_op == OP_SET) && (hit || free)) ||
                             ((req_op == OP_UNSET) && hit);
                    if (req_op == OP_GET) begin
                        resp_valid <= 1'b1;
                        state      <= IDLE;
                    end else begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    resp_valid <= 1'b1;
                    state      <= IDLE;
                end
                CLEAR: begin
                    if (init_done) begin
                        resp_valid <= 1'b1;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (ctrl_accept) begin
            req_op    <= ctrl_op;
            req_key   <= ctrl_key;
            req_value <= ctrl_value;
        end
        if (state == DECIDE) begin
            wr_sel      <= hit ? hit_idx : free_idx;
            resp_found  <= hit;
            resp_value  <= hit ? rd_value_arr[hit_idx] : '0;
            resp_status <= ((req_op == OP_SET) && !hit && !free) ? ST_FULL : ST_OK;
        end
        if (state == CLEAR) begin
            resp_found  <= 1'b0;
            resp_value  <= '0;
            resp_status <= ST_OK;
        end
    end

    // ============================
    // Lookup pipeline
    // ============================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid          <= 1'b0;
            lookup_resp_valid <= 1'b0;
        end else begin
            s1_valid          <= lookup_accept;
            lookup_resp_valid <= s1_valid;
        end
    end

    // Stage 2 compares against the key held from stage 1
    always_ff @(posedge clk) begin
        if (lookup_accept) begin
            s1_key <= lookup_key;
        end
        lookup_found <= |lk_hit;
        lookup_value <= (|lk_hit) ? lk_value_arr[lk_idx] : '0;
    end

endmodule

// ==== hdl/htable_store.sv ====
module htable_store #(
    parameter int HASH_WID = htable_pkg::HASH_WID
) (
    input logic          clk,
    input logic          rst_n,
    htable_tbl_intf.store tbl
);
    import htable_pkg::*;

    localparam int DEPTH = 2 ** HASH_WID;

    logic   mem_valid [DEPTH];
    key_t   mem_key   [DEPTH];
    value_t mem_value [DEPTH];

    logic                sweeping;
    logic [HASH_WID-1:0] sweep_cnt;

    // ============================
    // Clearing sweep
    // ============================

    // One slot per cycle, init_done follows a cycle after the last slot
    always_ff @(posedge clk) begin
        if (!rst_n || tbl.init) begin
            sweeping      <= 1'b1;
            sweep_cnt     <= '0;
            tbl.init_done <= 1'b0;
        end else begin
            if (sweeping) begin
                sweep_cnt <= sweep_cnt + 1'b1;
                if (sweep_cnt == HASH_WID'(DEPTH - 1)) begin
                    sweeping <= 1'b0;
                end
            end
            tbl.init_done <= !sweeping;
        end
    end

    // ============================
    // Storage and read ports
    // ============================

    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem_valid[sweep_cnt] <= 1'b0;
        end else if (tbl.wr_en) begin
            mem_valid[tbl.wr_addr] <= tbl.wr_valid;
            mem_key[tbl.wr_addr]   <= tbl.wr_key;
            mem_value[tbl.wr_addr] <= tbl.wr_value;
        end

        // Reads see the contents from before a same-cycle write
        if (tbl.rd_en) begin
            tbl.rd_valid <= mem_valid[tbl.rd_addr];
            tbl.rd_key   <= mem_key[tbl.rd_addr];
            tbl.rd_value <= mem_value[tbl.rd_addr];
        end
        if (tbl.lk_en) begin
            tbl.lk_valid <= mem_valid[tbl.lk_addr];
            tbl.lk_key   <= mem_key[tbl.lk_addr];
            tbl.lk_value <= mem_value[tbl.lk_addr];
        end
    end

endmodule

// ==== hdl/htable_tbl_intf.sv ====
interface htable_tbl_intf #(
    parameter int HASH_WID = htable_pkg::HASH_WID
) ();
    import htable_pkg::*;

    // Control read port
    logic                rd_en;
    logic [HASH_WID-1:0] rd_addr;
    logic                rd_valid;
    key_t                rd_key;
    value_t              rd_value;

    // Lookup read port
    logic                lk_en;
    logic [HASH_WID-1:0] lk_addr;
    logic                lk_valid;
    key_t                lk_key;
    value_t              lk_value;

    // Single write port
    logic                wr_en;
    logic [HASH_WID-1:0] wr_addr;
    logic                wr_valid;
    key_t                wr_key;
    value_t              wr_value;

    // Clearing sweep
    logic                init;
    logic                init_done;

    modport core (
        output rd_en, rd_addr, lk_en, lk_addr,
        output wr_en, wr_addr, wr_valid, wr_key, wr_value, init,
        input  rd_valid, rd_key, rd_value, lk_valid, lk_key, lk_value, init_done
    );

    modport store (
        input  rd_en, rd_addr, lk_en, lk_addr,
        input  wr_en, wr_addr, wr_valid, wr_key, wr_value, init,
        output rd_valid, rd_key, rd_value, lk_valid, lk_key, lk_value, init_done
    );

endinterface

// ==== hdl/htable_pkg.sv ====
package htable_pkg;

    // ============================
    // Default geometry
    // ============================

    localparam int KEY_WID   = 32;
    localparam int VALUE_WID = 32;

    // Slot index width, 16 slots per table
    localparam int HASH_WID  = 4;

    // Table i hashes on key bits [i*HASH_WID +: HASH_WID]
    localparam int NUM_TABLES = 2;

    // ============================
    // Entry types
    // ============================

    typedef logic [KEY_WID-1:0]   key_t;
    typedef logic [VALUE_WID-1:0] value_t;
    typedef logic [HASH_WID-1:0]  hash_t;

endpackage

// ==== hdl/db_pkg.sv ====
package db_pkg;

    // ============================
    // Control operations
    // ============================

    // Set covers both insert and replace
    // Unset returns the old value
    typedef enum logic [1:0] {
        OP_GET   = 2'd0,
        OP_SET   = 2'd1,
        OP_UNSET = 2'd2,
        OP_CLEAR = 2'd3
    } db_op_t;

    // ============================
    // Response status
    // ============================

    // FULL when a set finds no matching key and no empty slot
    typedef enum logic {
        ST_OK   = 1'b0,
        ST_FULL = 1'b1
    } db_status_t;

endpackage
